// File: sim.f
verilog/usb_rx_pkg.sv
verilog/usb_line_recovery.sv
verilog/usb_bit_decoder.sv
verilog/usb_token_decoder.sv
verilog/usb_data_decoder.sv
verilog/usb_packet_checker.sv
verilog/usb_fs_rx_top.sv
verif/usb_rx_asserts.sv
verif/usb_rx_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := usb_rx_tb
FILELIST   := sim.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: verif/usb_rx_tb.sv
/*
 * testbench of the full-speed USB receiver with clock, reset and packet encoder
 * token, data, PID, bit-stuff and EOP tests, value checks, report and watchdog
 */
`timescale 1ns/1ps

module usb_rx_tb;

  import usb_rx_pkg::*;

  localparam int         NUM_PACKETS = 9;
  localparam int         BIT_NS      = 16;
  localparam int         END_WAIT    = 400;
  localparam logic [1:0] LINE_J      = 2'b10;
  localparam logic [1:0] LINE_K      = 2'b01;
  localparam logic [1:0] LINE_SE0    = 2'b00;

  logic        clk_i;
  logic        rst_ni;
  logic        link_reset_i;
  logic        cfg_eop_single_bit_i;
  logic        usb_dp_i;
  logic        usb_dn_i;
  logic        pkt_start_o;
  logic        pkt_end_o;
  usb_pid_e    pid_o;
  logic [6:0]  addr_o;
  logic [3:0]  endp_o;
  logic [10:0] frame_num_o;
  logic        rx_data_put_o;
  logic [7:0]  rx_data_o;
  logic        valid_pid_o;
  logic        valid_packet_o;
  logic        crc5_error_o;
  logic        crc16_error_o;
  logic        pid_error_o;
  logic        bitstuff_error_o;

  // payload bits after the PID in wire order, CRC included
  bit         pay_q[$];
  logic [7:0] rx_bytes[$];
  logic [7:0] exp_bytes[$];

  // outputs as seen in the cycle of pkt_end_o
  int       end_cnt = 0;
  usb_pid_e snap_pid;
  logic     snap_valid_pid;
  logic     snap_valid_pkt;
  logic     snap_crc5_err;
  logic     snap_crc16_err;
  logic     snap_pid_err;
  logic     snap_stuff_err;

  int checks = 0;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;

  usb_fs_rx_top usb_fs_rx_top_inst (.*);

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // monitor
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (pkt_start_o) begin
        rx_bytes.delete();
      end
      if (rx_data_put_o) begin
        rx_bytes.push_back(rx_data_o);
      end
      if (pkt_end_o) begin
        snap_pid       = pid_o;
        snap_valid_pid = valid_pid_o;
        snap_valid_pkt = valid_packet_o;
        snap_crc5_err  = crc5_error_o;
        snap_crc16_err = crc16_error_o;
        snap_pid_err   = pid_error_o;
        snap_stuff_err = bitstuff_error_o;
        end_cnt++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // encoder and helpers
  ////////////////////////////////////////////////////////////

  // one symbol lasts four clocks, starting and ending on a falling edge
  task automatic send_sym(input logic [1:0] s);
    usb_dp_i = s[1];
    usb_dn_i = s[0];
    repeat (4) @(negedge clk_i);
  endtask

  task automatic send_packet(input logic [7:0] pid_byte, input bit do_stuff,
                             input int eop_bits);
    bit         raw[$];
    logic [1:0] lvl;
    int         ones;
    for (int i = 0; i < 8; i++) raw.push_back(pid_byte[i]);
    foreach (pay_q[i]) raw.push_back(pay_q[i]);
    // sync is KJKJKJKK
    repeat (3) begin
      send_sym(LINE_K);
      send_sym(LINE_J);
    end
    send_sym(LINE_K);
    send_sym(LINE_K);
    lvl  = LINE_K;
    ones = 0;
    // in NRZI a zero toggles the line and a one keeps it
    foreach (raw[i]) begin
      if (!raw[i]) lvl = ~lvl;
      send_sym(lvl);
      ones = raw[i] ? ones + 1 : 0;
      if (do_stuff && ones == 6) begin
        lvl  = ~lvl;
        send_sym(lvl);
        ones = 0;
      end
    end
    repeat (eop_bits) send_sym(LINE_SE0);
    repeat (3) send_sym(LINE_J);
  endtask

  // USB CRC5, x^5+x^2+1, preset to ones, sent inverted MSB first
  task automatic append_crc5();
    logic [4:0] c;
    c = 5'h1f;
    foreach (pay_q[i]) begin
      c = (pay_q[i] ^ c[4]) ? ({c[3:0], 1'b0} ^ 5'h05) : {c[3:0], 1'b0};
    end
    for (int i = 4; i >= 0; i--) pay_q.push_back(~c[i]);
  endtask

  // USB CRC16, x^16+x^15+x^2+1, preset to ones, sent inverted MSB first
  task automatic append_crc16();
    logic [15:0] c;
    c = 16'hffff;
    foreach (pay_q[i]) begin
      c = (pay_q[i] ^ c[15]) ? ({c[14:0], 1'b0} ^ 16'h8005) : {c[14:0], 1'b0};
    end
    for (int i = 15; i >= 0; i--) pay_q.push_back(~c[i]);
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp,
                          input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic wait_packet_end(input int start_cnt);
    int n;
    n = 0;
    while (end_cnt == start_cnt && n < END_WAIT) begin
      @(negedge clk_i);
      n++;
    end
    if (end_cnt == start_cnt) begin
      errors++;
      $display("the receiver never signalled a packet end, at %0t ns", $time);
    end
    repeat (2) send_sym(LINE_J);
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors > err_before) begin
      tests_failed++;
      $display("test %s: failed", name);
    end else begin
      $display("test %s: passed", name);
    end
  endtask

  // error flags that must stay quiet in a packet
  task automatic check_no_errors();
    check_eq(32'(snap_crc5_err), 32'd0, "crc5_error_o");
    check_eq(32'(snap_crc16_err), 32'd0, "crc16_error_o");
    check_eq(32'(snap_pid_err), 32'd0, "pid_error_o");
    check_eq(32'(snap_stuff_err), 32'd0, "bitstuff_error_o");
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  task automatic token_test(input string name, input usb_pid_e pid,
                            input logic [10:0] field, input bit bad_crc);
    int e0;
    int start;
    e0 = errors;
    pay_q.delete();
    for (int i = 0; i < 11; i++) pay_q.push_back(field[i]);
    append_crc5();
    if (bad_crc) pay_q[13] = ~pay_q[13];
    start = end_cnt;
    send_packet({~pid, pid}, 1'b1, 2);
    wait_packet_end(start);
    check_eq(32'(snap_pid), 32'(pid), "pid_o");
    check_eq(32'(snap_valid_pid), 32'd1, "valid_pid_o");
    check_eq(32'(snap_valid_pkt), 32'(!bad_crc), "valid_packet_o");
    check_eq(32'(snap_crc5_err), 32'(bad_crc), "crc5_error_o");
    // data bytes belong to data packets only
    check_eq(32'(rx_bytes.size()), 32'd0, "bytes put in a token");
    if (!bad_crc) begin
      check_no_errors();
      check_eq(32'(addr_o), 32'(field[6:0]), "addr_o");
      check_eq(32'(endp_o), 32'(field[10:7]), "endp_o");
      check_eq(32'(frame_num_o), 32'(field), "frame_num_o");
    end
    finish_test(name, e0);
  endtask

  task automatic data_test(input string name, input int nbytes,
                           input bit first_ff, input bit bad_crc);
    logic [7:0] b;
    int         e0;
    int         start;
    e0 = errors;
    pay_q.delete();
    for (int i = 0; i < nbytes; i++) begin
      b = (first_ff && i == 0) ? 8'hff : 8'($urandom);
      for (int j = 0; j < 8; j++) pay_q.push_back(b[j]);
    end
    append_crc16();
    if (bad_crc) pay_q[pay_q.size() - 3] = ~pay_q[pay_q.size() - 3];
    // bytes are collected LSB first, the CRC bytes too
    exp_bytes.delete();
    for (int i = 0; i < pay_q.size() / 8; i++) begin
      for (int j = 0; j < 8; j++) b[j] = pay_q[8 * i + j];
      exp_bytes.push_back(b);
    end
    start = end_cnt;
    send_packet({~PID_DATA0, PID_DATA0}, 1'b1, 2);
    wait_packet_end(start);
    check_eq(32'(rx_bytes.size()), 32'(exp_bytes.size()), "byte count");
    for (int i = 0; i < exp_bytes.size() && i < rx_bytes.size(); i++) begin
      check_eq(32'(rx_bytes[i]), 32'(exp_bytes[i]), "rx_data_o");
    end
    check_eq(32'(snap_pid), 32'(PID_DATA0), "pid_o");
    check_eq(32'(snap_valid_pkt), 32'(!bad_crc), "valid_packet_o");
    check_eq(32'(snap_crc16_err), 32'(bad_crc), "crc16_error_o");
    finish_test(name, e0);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    int e0;
    int start;
    int total_err;
    void'($urandom(32'hdac7_5de0));
    rst_ni               = 1'b0;
    link_reset_i         = 1'b0;
    cfg_eop_single_bit_i = 1'b0;
    usb_dp_i             = 1'b1;
    usb_dn_i             = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    repeat (4) send_sym(LINE_J);

    token_test("token_out", PID_OUT, 11'($urandom), 1'b0);
    token_test("token_sof", PID_SOF, 11'($urandom), 1'b0);

    // a link reset right after a good SOF clears the held fields and flags
    e0 = errors;
    link_reset_i = 1'b1;
    repeat (5) @(negedge clk_i);
    check_eq(32'(addr_o), 32'd0, "addr_o after link reset");
    check_eq(32'(frame_num_o), 32'd0, "frame_num_o after link reset");
    check_eq(32'(valid_pid_o), 32'd0, "valid_pid_o after link reset");
    check_eq(32'(valid_packet_o), 32'd0, "valid_packet_o after link reset");
    link_reset_i = 1'b0;
    repeat (2) send_sym(LINE_J);
    finish_test("link_reset", e0);

    token_test("token_crc_error", PID_IN, 11'($urandom), 1'b1);

    data_test("data_random", 1 + int'($urandom % 8), 1'b0, 1'b0);
    data_test("data_stuffed", 8, 1'b1, 1'b0);
    data_test("data_crc_error", 1 + int'($urandom % 8), 1'b0, 1'b1);

    // check nibble equal to the value instead of its complement
    e0 = errors;
    pay_q.delete();
    start = end_cnt;
    send_packet(8'b0010_0010, 1'b1, 2);
    wait_packet_end(start);
    check_eq(32'(snap_pid_err), 32'd1, "pid_error_o");
    check_eq(32'(snap_valid_pid), 32'd0, "valid_pid_o");
    check_eq(32'(snap_valid_pkt), 32'd0, "valid_packet_o");
    finish_test("pid_error", e0);

    // eight ones with no stuffed zero
    e0 = errors;
    pay_q.delete();
    repeat (8) pay_q.push_back(1'b1);
    start = end_cnt;
    send_packet({~PID_DATA0, PID_DATA0}, 1'b0, 2);
    wait_packet_end(start);
    check_eq(32'(snap_stuff_err), 32'd1, "bitstuff_error_o");
    check_eq(32'(snap_valid_pkt), 32'd0, "valid_packet_o");
    finish_test("bitstuff_error", e0);

    // a handshake closed by a single SE0 bit
    e0 = errors;
    cfg_eop_single_bit_i = 1'b1;
    pay_q.delete();
    start = end_cnt;
    send_packet({~PID_ACK, PID_ACK}, 1'b1, 1);
    wait_packet_end(start);
    check_eq(32'(snap_pid), 32'(PID_ACK), "pid_o");
    check_eq(32'(snap_valid_pid), 32'd1, "valid_pid_o");
    check_eq(32'(snap_valid_pkt), 32'd1, "valid_packet_o");
    check_no_errors();
    cfg_eop_single_bit_i = 1'b0;
    finish_test("eop_single_bit", e0);

    total_err = errors + int'(usb_fs_rx_top_inst.usb_rx_asserts_inst.assert_fails);
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, total_err);
    if (total_err == 0 && tests_failed == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // about 200 bit times per packet at most
  initial begin
    #(NUM_PACKETS * 200 * BIT_NS);
    $display("the run took longer than expected and was stopped by the watchdog");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: verif/usb_rx_asserts.sv
/*
 * concurrent protocol checks on the receiver outputs,
 * bound into the top level
 */
`timescale 1ns/1ps

module usb_rx_asserts (
  input logic clk_i,
  input logic rst_ni,
  input logic link_reset_i,
  input logic pkt_start_i,
  input logic pkt_end_i,
  input logic rx_data_put_i,
  input logic valid_packet_i,
  input logic crc5_error_i,
  input logic crc16_error_i,
  input logic pid_error_i,
  input logic bitstuff_error_i
);

  logic        any_err;
  logic        in_pkt_q;
  int unsigned assert_fails = 0;

  assign any_err = crc5_error_i | crc16_error_i | pid_error_i | bitstuff_error_i;

  // set from the start pulse up to and including the end pulse
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_pkt_q <= 1'b0;
    end else if (pkt_start_i) begin
      in_pkt_q <= 1'b1;
    end else if (pkt_end_i) begin
      in_pkt_q <= 1'b0;
    end
  end

  err_at_end: assert property (@(posedge clk_i) disable iff (!rst_ni)
    any_err |-> pkt_end_i)
    else begin
      assert_fails++;
      $error("error pulse outside the packet end");
    end

  valid_no_err: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(valid_packet_i && any_err))
    else begin
      assert_fails++;
      $error("valid packet flagged together with an error pulse");
    end

  put_in_packet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_data_put_i |-> in_pkt_q)
    else begin
      assert_fails++;
      $error("data byte put outside a packet");
    end

  // the first cycle of a link reset still shows the old register state
  quiet_in_reset: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (link_reset_i && $past(link_reset_i)) |->
      !(pkt_start_i || pkt_end_i || rx_data_put_i || any_err || valid_packet_i))
    else begin
      assert_fails++;
      $error("output pulse during link reset");
    end

endmodule

bind usb_fs_rx_top usb_rx_asserts usb_rx_asserts_inst (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .link_reset_i     (link_reset_i),
  .pkt_start_i      (pkt_start_o),
  .pkt_end_i        (pkt_end_o),
  .rx_data_put_i    (rx_data_put_o),
  .valid_packet_i   (valid_packet_o),
  .crc5_error_i     (crc5_error_o),
  .crc16_error_i    (crc16_error_o),
  .pid_error_i      (pid_error_o),
  .bitstuff_error_i (bitstuff_error_o)
);

// File: verilog/usb_fs_rx_top.sv
/*
 * full-speed USB packet receiver, top level wiring only
 */
`timescale 1ns/1ps

module usb_fs_rx_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 link_reset_i,
  input  logic                 cfg_eop_single_bit_i,
  input  logic                 usb_dp_i,
  input  logic                 usb_dn_i,
  output logic                 pkt_start_o,
  output logic                 pkt_end_o,
  output usb_rx_pkg::usb_pid_e pid_o,
  output logic [6:0]           addr_o,
  output logic [3:0]           endp_o,
  output logic [10:0]          frame_num_o,
  output logic                 rx_data_put_o,
  output logic [7:0]           rx_data_o,
  output logic                 valid_pid_o,
  output logic                 valid_packet_o,
  output logic                 crc5_error_o,
  output logic                 crc16_error_o,
  output logic                 pid_error_o,
  output logic                 bitstuff_error_o
);

  import usb_rx_pkg::*;

  line_evt_t evt;
  rx_bit_t   rx_bit;
  pid_info_t pid_info;
  logic      bitstuff_err;
  logic      crc5_ok;
  logic      crc16_ok;

  // the registered bit-stuff error loops back to force an EOP
  usb_line_recovery usb_line_recovery_inst (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .link_reset_i         (link_reset_i),
    .cfg_eop_single_bit_i (cfg_eop_single_bit_i),
    .usb_dp_i             (usb_dp_i),
    .usb_dn_i             (usb_dn_i),
    .bitstuff_err_i       (bitstuff_err),
    .evt_o                (evt)
  );

  usb_bit_decoder usb_bit_decoder_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .link_reset_i   (link_reset_i),
    .evt_i          (evt),
    .bit_o          (rx_bit),
    .pid_o          (pid_info),
    .bitstuff_err_o (bitstuff_err)
  );

  // token and data decoding run side by side on the same bit stream
  usb_token_decoder usb_token_decoder_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .link_reset_i (link_reset_i),
    .bit_i        (rx_bit),
    .pid_i        (pid_info),
    .addr_o       (addr_o),
    .endp_o       (endp_o),
    .frame_num_o  (frame_num_o),
    .crc5_ok_o    (crc5_ok)
  );

  usb_data_decoder usb_data_decoder_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .link_reset_i  (link_reset_i),
    .bit_i         (rx_bit),
    .pid_i         (pid_info),
    .rx_data_put_o (rx_data_put_o),
    .rx_data_o     (rx_data_o),
    .crc16_ok_o    (crc16_ok)
  );

  usb_packet_checker usb_packet_checker_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .link_reset_i     (link_reset_i),
    .bit_i            (rx_bit),
    .pid_i            (pid_info),
    .crc5_ok_i        (crc5_ok),
    .crc16_ok_i       (crc16_ok),
    .bitstuff_err_i   (bitstuff_err),
    .valid_packet_o   (valid_packet_o),
    .crc5_error_o     (crc5_error_o),
    .crc16_error_o    (crc16_error_o),
    .pid_error_o      (pid_error_o),
    .bitstuff_error_o (bitstuff_error_o)
  );

  assign pkt_start_o = evt.pkt_start;
  assign pkt_end_o   = evt.pkt_end;
  assign pid_o       = pid_info.pid;
  assign valid_pid_o = pid_info.pid_ok;

endmodule

// File: verilog/usb_packet_checker.sv
/*
 * payload length counting and the per-class validity rules,
 * error pulses at the end of packet
 */
`timescale 1ns/1ps

module usb_packet_checker (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  link_reset_i,
  input  usb_rx_pkg::rx_bit_t   bit_i,
  input  usb_rx_pkg::pid_info_t pid_i,
  input  logic                  crc5_ok_i,
  input  logic                  crc16_ok_i,
  input  logic                  bitstuff_err_i,
  output logic                  valid_packet_o,
  output logic                  crc5_error_o,
  output logic                  crc16_error_o,
  output logic                  pid_error_o,
  output logic                  bitstuff_error_o
);

  import usb_rx_pkg::*;

  logic [$clog2(TOKEN_BITS)-1:0] bit_cnt_q;
  logic                          len16_q;
  logic                          past16_q;
  logic                          class_ok;
  logic                          pid_good;
  logic                          is_token;
  logic                          is_data;

  // the counter wraps every sixteen bits, the flags remember what it passed
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bit_cnt_q <= '0;
      len16_q   <= 1'b0;
      past16_q  <= 1'b0;
    end else if (link_reset_i || bit_i.pkt_start) begin
      bit_cnt_q <= '0;
      len16_q   <= 1'b0;
      past16_q  <= 1'b0;
    end else if (bit_i.bit_valid) begin
      bit_cnt_q <= bit_cnt_q + 1'b1;
      if (&bit_cnt_q) begin
        len16_q <= 1'b1;
      end
      if (len16_q) begin
        past16_q <= 1'b1;
      end
    end
  end

  // tokens need exactly sixteen bits, data a whole number of bytes with the CRC
  always_comb begin
    unique case (pid_i.pid_class)
      PID_CLASS_TOKEN:     class_ok = len16_q && !past16_q && crc5_ok_i;
      PID_CLASS_DATA:      class_ok = len16_q && (bit_cnt_q[2:0] == 3'd0) && crc16_ok_i;
      PID_CLASS_HANDSHAKE: class_ok = !len16_q && (bit_cnt_q == '0);
      default:             class_ok = 1'b0;
    endcase
  end

  assign pid_good = pid_i.pid_ok && pid_i.pid_done;
  assign is_token = (pid_i.pid_class == PID_CLASS_TOKEN);
  assign is_data  = (pid_i.pid_class == PID_CLASS_DATA);

  // stays as it was at the EOP until the next packet starts
  assign valid_packet_o = pid_good && !bitstuff_err_i && class_ok;

  assign crc5_error_o     = bit_i.pkt_end && is_token && !crc5_ok_i;
  assign crc16_error_o    = bit_i.pkt_end && is_data && !crc16_ok_i;
  assign pid_error_o      = bit_i.pkt_end && !pid_good;
  assign bitstuff_error_o = bit_i.pkt_end && bitstuff_err_i;

endmodule

// File: verilog/usb_data_decoder.sv
/*
 * CRC16 over the payload bits and assembly of data bytes
 */
`timescale 1ns/1ps

module usb_data_decoder (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  link_reset_i,
  input  usb_rx_pkg::rx_bit_t   bit_i,
  input  usb_rx_pkg::pid_info_t pid_i,
  output logic                  rx_data_put_o,
  output logic [7:0]            rx_data_o,
  output logic                  crc16_ok_o
);

  import usb_rx_pkg::*;

  logic [15:0] crc16_q;
  logic        crc16_fb;
  logic        is_data;
  logic [8:0]  byte_q;
  logic        byte_full;

  assign crc16_fb   = bit_i.bit_data ^ crc16_q[15];
  assign crc16_ok_o = (crc16_q == CRC16_RESIDUAL);
  assign is_data    = (pid_i.pid_class == PID_CLASS_DATA);

  // eight bits push the sentinel down to bit zero, and that is the put strobe
  assign byte_full = byte_q[0];

  ////////////////////////////////////////////////////////////
  // CRC16 and byte assembly
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      crc16_q <= '0;
      byte_q  <= '0;
    end else if (link_reset_i) begin
      crc16_q <= '0;
      byte_q  <= '0;
    end else begin
      // only unstuffed payload bits advance the CRC
      if (bit_i.pkt_start) begin
        crc16_q <= CRC16_INIT;
      end else if (bit_i.bit_valid) begin
        crc16_q <= {crc16_q[14:0], 1'b0} ^ ({16{crc16_fb}} & CRC16_POLY);
      end
      // bits are at least four clocks apart, so a full byte is always
      // emptied before the next bit can arrive
      if (bit_i.pkt_start || byte_full) begin
        byte_q <= 9'b1_0000_0000;
      end else if (bit_i.bit_valid && is_data) begin
        byte_q <= {bit_i.bit_data, byte_q[8:1]};
      end
    end
  end

  // bytes leave LSB first as single-cycle pulses, the two CRC bytes included
  assign rx_data_put_o = byte_full;
  assign rx_data_o     = byte_q[8:1];

endmodule

// File: verilog/usb_token_decoder.sv
/*
 * CRC5 over the payload bits and capture of address, endpoint
 * and frame number from token packets
 */
`timescale 1ns/1ps

module usb_token_decoder (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  link_reset_i,
  input  usb_rx_pkg::rx_bit_t   bit_i,
  input  usb_rx_pkg::pid_info_t pid_i,
  output logic [6:0]            addr_o,
  output logic [3:0]            endp_o,
  output logic [10:0]           frame_num_o,
  output logic                  crc5_ok_o
);

  import usb_rx_pkg::*;

  logic [4:0]  crc5_q;
  logic        crc5_fb;
  logic        is_token;
  logic [11:0] token_q;
  logic        token_done;
  logic [6:0]  addr_q;
  logic [3:0]  endp_q;
  logic [10:0] frame_num_q;

  // the CRC is shifted MSB first while the bits arrive LSB first
  assign crc5_fb    = bit_i.bit_data ^ crc5_q[4];
  assign crc5_ok_o  = (crc5_q == CRC5_RESIDUAL);
  assign is_token   = (pid_i.pid_class == PID_CLASS_TOKEN);
  // eleven field bits push the sentinel down to bit zero
  assign token_done = token_q[0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      crc5_q      <= '0;
      token_q     <= '0;
      addr_q      <= '0;
      endp_q      <= '0;
      frame_num_q <= '0;
    end else if (link_reset_i) begin
      crc5_q      <= '0;
      token_q     <= '0;
      addr_q      <= '0;
      endp_q      <= '0;
      frame_num_q <= '0;
    end else begin
      // the CRC runs over every payload bit, including the CRC itself
      if (bit_i.pkt_start) begin
        crc5_q <= CRC5_INIT;
      end else if (bit_i.bit_valid) begin
        crc5_q <= {crc5_q[3:0], 1'b0} ^ ({5{crc5_fb}} & CRC5_POLY);
      end
      if (bit_i.pkt_start) begin
        token_q <= 12'b1000_0000_0000;
      end else if (bit_i.bit_valid && is_token && !token_done) begin
        token_q <= {bit_i.bit_data, token_q[11:1]};
      end
      // the same eleven bits are either address and endpoint or a frame number
      if (token_done && is_token) begin
        addr_q      <= token_q[7:1];
        endp_q      <= token_q[11:8];
        frame_num_q <= token_q[11:1];
      end
    end
  end

  assign addr_o      = addr_q;
  assign endp_o      = endp_q;
  assign frame_num_o = frame_num_q;

endmodule

// File: verilog/usb_bit_decoder.sv
/*
 * NRZI decode, bit-stuff removal and error tracking,
 * PID capture and check
 */
`timescale 1ns/1ps

module usb_bit_decoder (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  link_reset_i,
  input  usb_rx_pkg::line_evt_t evt_i,
  output usb_rx_pkg::rx_bit_t   bit_o,
  output usb_rx_pkg::pid_info_t pid_o,
  output logic                  bitstuff_err_o
);

  import usb_rx_pkg::*;

  logic [3:0]          sym_hist_q;
  logic                both_kj;
  logic                din;
  logic                dvalid_raw;
  logic                dvalid;
  logic [MAX_ONES-1:0] ones_q;
  logic                stuff_bit;
  logic                stuff_err;
  logic                bitstuff_err_q;
  logic [8:0]          full_pid_q;

  ////////////////////////////////////////////////////////////
  // NRZI decode
  ////////////////////////////////////////////////////////////

  // decode from the two previous samples, a K or J has its two bits unequal
  assign both_kj    = (^sym_hist_q[3:2]) && (^sym_hist_q[1:0]);
  // no change on the line is a one, a change is a zero
  assign din        = (sym_hist_q[3:2] == sym_hist_q[1:0]);
  assign dvalid_raw = evt_i.sample_valid && evt_i.pkt_active && both_kj;

  ////////////////////////////////////////////////////////////
  // bit stuffing
  ////////////////////////////////////////////////////////////

  // after six ones the sender inserts a zero which is not payload
  assign stuff_bit = &ones_q;
  assign dvalid    = dvalid_raw && !stuff_bit;
  // a one where the stuffed zero belongs is a stuffing violation
  assign stuff_err = dvalid_raw && din && stuff_bit;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sym_hist_q     <= 4'b1010;
      ones_q         <= '0;
      bitstuff_err_q <= 1'b0;
      full_pid_q     <= '0;
    end else if (link_reset_i) begin
      sym_hist_q     <= 4'b1010;
      ones_q         <= '0;
      bitstuff_err_q <= 1'b0;
      full_pid_q     <= '0;
    end else begin
      if (evt_i.sample_valid) begin
        sym_hist_q <= {sym_hist_q[1:0], evt_i.sym[1:0]};
      end
      if (evt_i.pkt_end) begin
        ones_q <= '0;
      end else if (dvalid_raw) begin
        ones_q <= {ones_q[MAX_ONES-2:0], din};
      end
      // the error is held until the next packet so that the EOP can see it
      if (evt_i.pkt_start) begin
        bitstuff_err_q <= 1'b0;
      end else if (stuff_err) begin
        bitstuff_err_q <= 1'b1;
      end
      // the PID shifts in behind a sentinel one, which marks it complete
      if (evt_i.pkt_start) begin
        full_pid_q <= 9'b1_0000_0000;
      end else if (dvalid && !full_pid_q[0]) begin
        full_pid_q <= {din, full_pid_q[8:1]};
      end
    end
  end

  assign bitstuff_err_o = bitstuff_err_q;

  // only the bits after the PID are passed on as payload
  always_comb begin
    bit_o.bit_valid = dvalid && full_pid_q[0];
    bit_o.bit_data  = din;
    bit_o.pkt_start = evt_i.pkt_start;
    bit_o.pkt_end   = evt_i.pkt_end;
  end

  // the upper nibble must be the complement of the PID value
  always_comb begin
    pid_o.pid       = usb_pid_e'(full_pid_q[4:1]);
    pid_o.pid_class = pid_class_e'(full_pid_q[2:1]);
    pid_o.pid_ok    = (full_pid_q[4:1] == ~full_pid_q[8:5]);
    pid_o.pid_done  = full_pid_q[0];
  end

endmodule

// File: verilog/usb_line_recovery.sv
/*
 * line state recovery with a one clock settle after each change of the pair,
 * bit phase tracking and sync and EOP detection
 */
`timescale 1ns/1ps

module usb_line_recovery (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  link_reset_i,
  input  logic                  cfg_eop_single_bit_i,
  input  logic                  usb_dp_i,
  input  logic                  usb_dn_i,
  input  logic                  bitstuff_err_i,
  output usb_rx_pkg::line_evt_t evt_o
);

  import usb_rx_pkg::*;

  line_sym_e   line_state_q, line_state_d;
  logic [1:0]  dpair;
  logic [1:0]  bit_phase_q;
  logic        sample_valid;
  logic [11:0] history_q;
  logic        pkt_valid_q, pkt_valid_d;
  logic        see_eop;

  assign dpair = {usb_dp_i, usb_dn_i};

  ////////////////////////////////////////////////////////////
  // line state FSM
  ////////////////////////////////////////////////////////////

  // any change on the pair parks the FSM in DT for one clock, so that a
  // skew between dp and dn is never decoded as a symbol of its own
  always_comb begin
    line_state_d = line_state_q;
    if (line_state_q == SYM_DT) begin
      line_state_d = line_sym_e'({1'b0, dpair});
    end else if (dpair != line_state_q[1:0]) begin
      line_state_d = SYM_DT;
    end
  end

  // a DT realigns the bit phase, the line is then sampled mid-bit
  assign sample_valid = (bit_phase_q == BIT_PHASE_SAMPLE);

  ////////////////////////////////////////////////////////////
  // packet framing
  ////////////////////////////////////////////////////////////

  // one or two SE0 samples close the packet, a bit-stuff error does too
  assign see_eop = (cfg_eop_single_bit_i && history_q[1:0] == 2'b00) ||
                   (history_q[3:0] == 4'b0000) || bitstuff_err_i;

  always_comb begin
    pkt_valid_d = pkt_valid_q;
    if (sample_valid) begin
      if (!pkt_valid_q && history_q == SYNC_PATTERN) begin
        pkt_valid_d = 1'b1;
      end else if (pkt_valid_q && see_eop) begin
        pkt_valid_d = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      line_state_q <= SYM_SE0;
      bit_phase_q  <= 2'd0;
      history_q    <= 12'hAAA;
      pkt_valid_q  <= 1'b0;
    end else if (link_reset_i) begin
      line_state_q <= SYM_SE0;
      bit_phase_q  <= 2'd0;
      history_q    <= 12'hAAA;
      pkt_valid_q  <= 1'b0;
    end else begin
      line_state_q <= line_state_d;
      bit_phase_q  <= (line_state_q == SYM_DT) ? 2'd0 : bit_phase_q + 2'd1;
      // the history starts as an idle J line
      if (sample_valid) begin
        history_q <= {history_q[9:0], line_state_q[1:0]};
      end
      pkt_valid_q <= pkt_valid_d;
    end
  end

  // start and end pulses are the edges of the packet-valid flag
  always_comb begin
    evt_o.sample_valid = sample_valid;
    evt_o.sym          = line_state_q;
    evt_o.pkt_active   = pkt_valid_q;
    evt_o.pkt_start    = pkt_valid_d & ~pkt_valid_q;
    evt_o.pkt_end      = ~pkt_valid_d & pkt_valid_q;
  end

endmodule

// File: verilog/usb_rx_pkg.sv
/*
 * shared types and constants of the full-speed USB receiver
 * line symbols, PID codes and classes, per-cycle event structs
 */
package usb_rx_pkg;

  ////////////////////////////////////////////////////////////
  // line symbols, PIDs and PID classes
  ////////////////////////////////////////////////////////////

  // the low two bits of a symbol are the {dp, dn} pair as seen on the line
  typedef enum logic [2:0] {
    SYM_SE0 = 3'b000,
    SYM_K   = 3'b001,
    SYM_J   = 3'b010,
    SYM_DT  = 3'b100
  } line_sym_e;

  typedef enum logic [3:0] {
    PID_OUT   = 4'b0001,
    PID_IN    = 4'b1001,
    PID_SOF   = 4'b0101,
    PID_SETUP = 4'b1101,
    PID_DATA0 = 4'b0011,
    PID_DATA1 = 4'b1011,
    PID_DATA2 = 4'b0111,
    PID_MDATA = 4'b1111,
    PID_ACK   = 4'b0010,
    PID_NAK   = 4'b1010,
    PID_STALL = 4'b1110,
    PID_NYET  = 4'b0110,
    PID_PRE   = 4'b1100,
    PID_SPLIT = 4'b1000,
    PID_PING  = 4'b0100,
    PID_RSVD  = 4'b0000
  } usb_pid_e;

  // the class is simply the low two bits of the PID
  typedef enum logic [1:0] {
    PID_CLASS_SPECIAL   = 2'b00,
    PID_CLASS_TOKEN     = 2'b01,
    PID_CLASS_HANDSHAKE = 2'b10,
    PID_CLASS_DATA      = 2'b11
  } pid_class_e;

  ////////////////////////////////////////////////////////////
  // per-cycle structs between the pipeline stages
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic      sample_valid;
    line_sym_e sym;
    logic      pkt_active;
    logic      pkt_start;
    logic      pkt_end;
  } line_evt_t;

  typedef struct packed {
    logic bit_valid;
    logic bit_data;
    logic pkt_start;
    logic pkt_end;
  } rx_bit_t;

  typedef struct packed {
    usb_pid_e   pid;
    pid_class_e pid_class;
    logic       pid_ok;
    logic       pid_done;
  } pid_info_t;

  ////////////////////////////////////////////////////////////
  // protocol constants
  ////////////////////////////////////////////////////////////

  // KJKJKK with the oldest symbol in the top bits, two bits per symbol
  localparam logic [11:0] SYNC_PATTERN     = 12'b01_10_01_10_01_01;
  localparam logic [4:0]  CRC5_INIT        = 5'b11111;
  localparam logic [4:0]  CRC5_POLY        = 5'b00101;
  localparam logic [4:0]  CRC5_RESIDUAL    = 5'b01100;
  localparam logic [15:0] CRC16_INIT       = 16'hffff;
  localparam logic [15:0] CRC16_POLY       = 16'h8005;
  localparam logic [15:0] CRC16_RESIDUAL   = 16'b1000000000001101;
  localparam int unsigned MAX_ONES         = 6;
  localparam logic [1:0]  BIT_PHASE_SAMPLE = 2'd1;
  localparam int unsigned TOKEN_BITS       = 16;

endpackage
